// File: filelist.f
+incdir+include
source/ic_pkg.sv
source/ic_part_if.sv
source/ready_select.sv
source/ic_source_part.sv
source/ic_part_select.sv
source/ic_dest_deliver.sv
source/ic_interconnect.sv
sim/ic_tb.sv

// File: sim/ic_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_settings.svh"

module ic_tb;
    import ic_pkg::*;

    localparam int npp            = `IC_NODES_PER_PART;
    localparam int parts          = `IC_NUM_PARTS;
    localparam int flits_per_node = 24;
    localparam int total_flits    = NUM_NODES * flits_per_node;
    localparam int fair_cycles    = 16;
    localparam int watchdog_ns    = (total_flits * 20 + 100) * 10;

    typedef struct packed {
        flit_t data;
        addr_t nexthop;
        int    tag;
    } pending_t;

    logic                  clock;
    logic                  reset;
    logic                  enable;
    logic [NUM_NODES-1:0]  src_valid;
    logic [NUM_NODES-1:0]  src_urgent;
    flit_t [NUM_NODES-1:0] src_data;
    addr_t [NUM_NODES-1:0] src_nexthop;
    logic [NUM_NODES-1:0]  src_dequeue;
    logic [NUM_NODES-1:0]  dest_valid;
    flit_t                 dest_data;
    addr_t                 dest_nexthop;
    logic                  can_increment;

    // Per-node source queues and the in-flight expectation list
    flit_t    node_q [NUM_NODES][$];
    addr_t    hop_q  [NUM_NODES][$];
    pending_t pending_q [$];

    int          errors;
    int          delivered;
    int          en_count;
    int          idle_run [parts];
    logic        random_mode;
    logic [31:0] lfsr;

    ic_interconnect UUT (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .src_valid     (src_valid),
        .src_urgent    (src_urgent),
        .src_data      (src_data),
        .src_nexthop   (src_nexthop),
        .src_dequeue   (src_dequeue),
        .dest_valid    (dest_valid),
        .dest_data     (dest_data),
        .dest_nexthop  (dest_nexthop),
        .can_increment (can_increment)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic void log_error(input string msg);
        errors++;
        $display("error %0t ns: %s", $time, msg);
    endfunction

    // Outputs now reflect the flit dequeued one enabled edge before the last
    task automatic check_delivery();
        logic [NUM_NODES-1:0] want;
        pending_t             head;
        want = '0;
        if (pending_q.size() > 0 && pending_q[0].tag == en_count - 1)
        begin
            head = pending_q[0];
            want[head.nexthop] = 1'b1;
            assert (dest_valid == want && dest_data == head.data
                    && dest_nexthop == head.nexthop)
            else log_error($sformatf("dest %b/%h/%0d, expected %b/%h/%0d", dest_valid,
                dest_data, dest_nexthop, want, head.data, head.nexthop));
            if (enable)
            begin
                void'(pending_q.pop_front());
                delivered++;
            end
        end
        else
        begin
            assert (dest_valid == '0)
            else log_error($sformatf("dest_valid %b with no flit due", dest_valid));
        end
    endtask

    task automatic check_fairness();
        logic fair;
        logic taken;
        fair = (&src_valid) && (src_urgent == '0);
        for (int g = 0; g < parts; g++)
        begin
            taken = |src_dequeue[g*npp +: npp];
            if (!fair || taken)
                idle_run[g] = 0;
            else
                idle_run[g]++;
            assert (idle_run[g] < parts)
            else log_error($sformatf("partition %0d starved %0d cycles", g, idle_run[g]));
        end
        // Lowest valid node of the partition when nothing is urgent
        if (src_urgent == '0)
        begin
            for (int j = 0; j < NUM_NODES; j++)
            begin
                if (src_dequeue[j])
                begin
                    for (int k = (j / npp) * npp; k < j; k++)
                    begin
                        assert (!src_valid[k])
                        else log_error($sformatf("node %0d taken over node %0d", j, k));
                    end
                end
            end
        end
    endtask

    task automatic record_dequeues();
        pending_t entry;
        en_count++;
        for (int j = 0; j < NUM_NODES; j++)
        begin
            if (src_dequeue[j] && node_q[j].size() > 0)
            begin
                entry.data    = node_q[j].pop_front();
                entry.nexthop = hop_q[j].pop_front();
                entry.tag     = en_count;
                pending_q.push_back(entry);
            end
        end
    endtask

    task automatic drive_inputs();
        logic has;
        for (int j = 0; j < NUM_NODES; j++)
        begin
            has = node_q[j].size() > 0;
            src_valid[j]  <= has;
            src_urgent[j] <= has && random_mode && (take_bits(2) == 2'b00);
            if (has)
            begin
                src_data[j]    <= node_q[j][0];
                src_nexthop[j] <= hop_q[j][0];
            end
        end
        enable <= random_mode ? (take_bits(3) != 3'b000) : 1'b1;
    endtask

    always @(posedge clock)
    begin
        if (!reset)
        begin
            check_delivery();
            if (enable)
            begin
                check_fairness();
                record_dequeues();
            end
            drive_inputs();
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        $onehot0(src_dequeue) && ((src_dequeue & ~src_valid) == '0))
        else log_error($sformatf("dequeue %b for valid %b", src_dequeue, src_valid));

    assert property (@(posedge clock) disable iff (reset) !enable |-> (src_dequeue == '0))
        else log_error($sformatf("dequeue %b while disabled", src_dequeue));

    assert property (@(posedge clock) disable iff (reset)
        (enable && (src_valid != '0)) |-> (src_dequeue != '0))
        else log_error($sformatf("no dequeue for valid %b", src_valid));

    assert property (@(posedge clock) disable iff (reset)
        (((src_valid & src_urgent) != '0) && (src_dequeue != '0))
        |-> ((src_dequeue & src_urgent) != '0))
        else log_error($sformatf("dequeue %b skips urgent %b", src_dequeue, src_urgent));

    assert property (@(posedge clock) can_increment == (src_urgent == '0))
        else log_error($sformatf("can_increment %b for urgent %b", can_increment, src_urgent));

    assert property (@(posedge clock) disable iff (reset)
        !enable |=> $stable(dest_valid) && $stable(dest_data) && $stable(dest_nexthop))
        else log_error("destination outputs changed while disabled");

    assert property (@(posedge clock) $fell(reset) |-> (src_dequeue == '0) && (dest_valid == '0))
        else log_error($sformatf("after reset dequeue %b dest %b", src_dequeue, dest_valid));

    initial
    begin
        #(watchdog_ns);
        $display("timeout: only %0d of %0d flits delivered", delivered, total_flits);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        lfsr        = 32'he50ae553;
        errors      = 0;
        delivered   = 0;
        en_count    = 0;
        random_mode = 1'b0;
        reset       = 1'b1;
        enable      = 1'b0;
        src_valid   = '0;
        src_urgent  = '0;
        src_data    = '0;
        src_nexthop = '0;
        for (int g = 0; g < parts; g++)
            idle_run[g] = 0;
        for (int j = 0; j < NUM_NODES; j++)
        begin
            for (int f = 0; f < flits_per_node; f++)
            begin
                node_q[j].push_back(flit_t'(take_bits(`IC_FLIT_WIDTH)));
                hop_q[j].push_back(addr_t'(take_bits(`IC_ADDR_WIDTH) % NUM_NODES));
            end
        end

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // Steady full load first, then urgent bits and enable gaps
        repeat (fair_cycles) @(posedge clock);
        random_mode <= 1'b1;

        while (delivered < total_flits)
            @(posedge clock);
        repeat (4) @(posedge clock);

        if (pending_q.size() != 0)
        begin
            $display("%0d flits still in flight at end of run", pending_q.size());
            errors++;
        end

        $display("flits delivered %0d of %0d, errors %0d", delivered, total_flits, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/ic_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_settings.svh"

module ic_interconnect (
    input  wire logic                                         clock,
    input  wire logic                                         reset,
    input  wire logic                                         enable,
    input  wire logic          [ic_pkg::NUM_NODES-1:0]        src_valid,
    input  wire logic          [ic_pkg::NUM_NODES-1:0]        src_urgent,
    input  wire ic_pkg::flit_t [ic_pkg::NUM_NODES-1:0]        src_data,
    input  wire ic_pkg::addr_t [ic_pkg::NUM_NODES-1:0]        src_nexthop,
    output logic               [ic_pkg::NUM_NODES-1:0]        src_dequeue,
    output logic               [ic_pkg::NUM_NODES-1:0]        dest_valid,
    output ic_pkg::flit_t                                     dest_data,
    output ic_pkg::addr_t                                     dest_nexthop,
    output logic                                              can_increment
);
    import ic_pkg::*;

    localparam int npp = `IC_NODES_PER_PART;

    logic  sel_valid;
    flit_t sel_data;
    addr_t sel_nexthop;

    ic_part_if part_bus [`IC_NUM_PARTS] ();

    // Global node number is partition * npp + local index
    for (genvar g = 0; g < `IC_NUM_PARTS; g++)
    begin : g_src
        ic_source_part #(
            .n(npp)
        ) u_part (
            .clock       (clock),
            .reset       (reset),
            .enable      (enable),
            .src_valid   (src_valid[g*npp +: npp]),
            .src_urgent  (src_urgent[g*npp +: npp]),
            .src_data    (src_data[g*npp +: npp]),
            .src_nexthop (src_nexthop[g*npp +: npp]),
            .src_dequeue (src_dequeue[g*npp +: npp]),
            .part        (part_bus[g])
        );
    end

    ic_part_select u_select (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .parts         (part_bus),
        .sel_valid     (sel_valid),
        .sel_data      (sel_data),
        .sel_nexthop   (sel_nexthop),
        .can_increment (can_increment)
    );

    ic_dest_deliver u_deliver (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .sel_valid    (sel_valid),
        .sel_data     (sel_data),
        .sel_nexthop  (sel_nexthop),
        .dest_valid   (dest_valid),
        .dest_data    (dest_data),
        .dest_nexthop (dest_nexthop)
    );

endmodule

`default_nettype wire

// File: source/ic_dest_deliver.sv
`timescale 1ns/1ps
`default_nettype none

module ic_dest_deliver (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         enable,
    input  wire logic                         sel_valid,
    input  wire ic_pkg::flit_t                sel_data,
    input  wire ic_pkg::addr_t                sel_nexthop,
    output logic [ic_pkg::NUM_NODES-1:0]      dest_valid,
    output ic_pkg::flit_t                     dest_data,
    output ic_pkg::addr_t                     dest_nexthop
);
    import ic_pkg::*;

    logic [NUM_NODES-1:0] dest_dec;

    // One strobe per destination node
    always_comb
    begin
        for (int i = 0; i < NUM_NODES; i++)
            dest_dec[i] = sel_valid && (sel_nexthop == addr_t'(i));
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            dest_valid <= '0;
        else if (enable)
            dest_valid <= dest_dec;
    end

    // Flit travels alongside the strobe
    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            dest_data    <= sel_data;
            dest_nexthop <= sel_nexthop;
        end
    end

    // Out-of-range next-hop would be silently dropped
    assert property (@(posedge clock) disable iff (reset)
        sel_valid |-> (int'(sel_nexthop) < NUM_NODES))
        else $error("next-hop %0d beyond %0d nodes", sel_nexthop, NUM_NODES);

endmodule

`default_nettype wire

// File: source/ic_part_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "ic_settings.svh"

module ic_part_select (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         enable,
    ic_part_if.selector       parts [`IC_NUM_PARTS],
    output logic              sel_valid,
    output ic_pkg::flit_t     sel_data,
    output ic_pkg::addr_t     sel_nexthop,
    output logic              can_increment
);
    import ic_pkg::*;

    localparam int p  = `IC_NUM_PARTS;
    localparam int pw = (p > 1) ? $clog2(p) : 1;

    logic [p-1:0]  valid_vec;
    logic [p-1:0]  urgent_vec;
    logic [p-1:0]  cand;
    logic [p-1:0]  sel_vec;
    addr_t         s1_nexthop_arr [p];
    flit_t         s2_data_arr    [p];
    addr_t         s2_nexthop_arr [p];

    logic [pw-1:0] pick;
    logic          pick_valid;

    // Last partition granted, also the one whose stage 2 data is shown
    logic [pw-1:0] last_q;
    logic          sel_valid_q;

    for (genvar i = 0; i < p; i++)
    begin : g_part
        assign valid_vec[i]      = parts[i].s1_valid;
        assign urgent_vec[i]     = parts[i].s1_urgent;
        assign s1_nexthop_arr[i] = parts[i].s1_nexthop;
        assign s2_data_arr[i]    = parts[i].s2_data;
        assign s2_nexthop_arr[i] = parts[i].s2_nexthop;
        assign parts[i].select   = sel_vec[i];
    end

    assign cand = (|urgent_vec) ? (valid_vec & urgent_vec) : valid_vec;

    // Round robin search starting just after the last grant
    always_comb
    begin
        int idx;
        pick       = last_q;
        pick_valid = 1'b0;
        for (int off = p; off >= 1; off--)
        begin
            idx = int'(last_q) + off;
            if (idx >= p)
                idx = idx - p;
            if (cand[idx])
            begin
                pick       = pw'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    always_comb
    begin
        sel_vec = '0;
        if (enable && pick_valid)
            sel_vec[pick] = 1'b1;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            sel_valid_q <= 1'b0;
            last_q      <= pw'(p - 1);
        end
        else if (enable)
        begin
            sel_valid_q <= pick_valid;
            if (pick_valid)
                last_q <= pick;
        end
    end

    assign sel_valid     = sel_valid_q;
    assign sel_data      = s2_data_arr[last_q];
    assign sel_nexthop   = s2_nexthop_arr[last_q];
    assign can_increment = ~|urgent_vec;

    // Single grant, to a partition holding a flit with a reachable next-hop
    assert property (@(posedge clock) disable iff (reset)
        $onehot0(sel_vec) && ((sel_vec & ~valid_vec) == '0)
        && (!pick_valid || !enable || (int'(s1_nexthop_arr[pick]) < NUM_NODES)))
        else $error("select %b bad for valid %b", sel_vec, valid_vec);

endmodule

`default_nettype wire

// File: source/ic_source_part.sv
`timescale 1ns/1ps
`default_nettype none

module ic_source_part #(
    parameter int n = 2
) (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        enable,
    input  wire logic [n-1:0]                src_valid,
    input  wire logic [n-1:0]                src_urgent,
    input  wire ic_pkg::flit_t [n-1:0]       src_data,
    input  wire ic_pkg::addr_t [n-1:0]       src_nexthop,
    output logic      [n-1:0]                src_dequeue,
    ic_part_if.source                        part
);
    import ic_pkg::*;

    logic [n-1:0] grant;
    logic         any_valid;
    logic         any_urgent;

    flit_t        s1_data;
    addr_t        s1_nexthop;

    flit_t        s2_data_q;
    addr_t        s2_nexthop_q;

    ready_select #(
        .n(n)
    ) u_arb (
        .ready      (src_valid),
        .urgent     (src_urgent),
        .grant      (grant),
        .any_valid  (any_valid),
        .any_urgent (any_urgent)
    );

    // One-hot mux of the granted node
    always_comb
    begin
        s1_data    = '0;
        s1_nexthop = '0;
        for (int i = 0; i < n; i++)
        begin
            if (grant[i])
            begin
                s1_data    = src_data[i];
                s1_nexthop = src_nexthop[i];
            end
        end
    end

    assign part.s1_valid   = any_valid;
    assign part.s1_urgent  = any_urgent;
    assign part.s1_nexthop = s1_nexthop;

    // Node drops its flit only when this partition wins stage 2
    assign src_dequeue = part.select ? grant : '0;

    // Stage 2 register loads on every enabled edge
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            s2_data_q    <= '0;
            s2_nexthop_q <= '0;
        end
        else if (enable)
        begin
            s2_data_q    <= s1_data;
            s2_nexthop_q <= s1_nexthop;
        end
    end

    assign part.s2_data    = s2_data_q;
    assign part.s2_nexthop = s2_nexthop_q;

    // Selector grant must land on a valid node, and never while frozen
    assert property (@(posedge clock) disable iff (reset)
        ((src_dequeue & ~src_valid) == '0) && (enable || (src_dequeue == '0)))
        else $error("dequeue %b for valid %b enable %b", src_dequeue, src_valid, enable);

endmodule

`default_nettype wire

// File: source/ready_select.sv
`timescale 1ns/1ps
`default_nettype none

module ready_select #(
    parameter int n = 2
) (
    input  wire logic [n-1:0] ready,
    input  wire logic [n-1:0] urgent,
    output logic      [n-1:0] grant,
    output logic              any_valid,
    output logic              any_urgent
);

    logic [n-1:0] urgent_ready;
    logic [n-1:0] cand;

    assign urgent_ready = ready & urgent;
    assign any_valid    = |ready;
    assign any_urgent   = |urgent_ready;

    // Urgent nodes shadow all others when present
    assign cand = any_urgent ? urgent_ready : ready;

    // Isolate the lowest set bit
    assign grant = cand & (~cand + n'(1));

    // Exactly one ready node granted whenever any is ready
    always_comb
    begin
        assert #0 (((grant & ~ready) == '0) && ($onehot(grant) == any_valid))
            else $error("ready_select grant %b invalid for ready %b", grant, ready);
    end

endmodule

`default_nettype wire

// File: source/ic_part_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ic_part_if;
    import ic_pkg::*;

    // Stage 1, combinational from the partition arbiter
    logic  s1_valid;
    logic  s1_urgent;
    addr_t s1_nexthop;

    // Stage 2, registered in the partition
    flit_t s2_data;
    addr_t s2_nexthop;

    // Selector grant back to the partition
    logic  select;

    modport source (
        output s1_valid,
        output s1_urgent,
        output s1_nexthop,
        output s2_data,
        output s2_nexthop,
        input  select
    );

    modport selector (
        input  s1_valid,
        input  s1_urgent,
        input  s1_nexthop,
        input  s2_data,
        input  s2_nexthop,
        output select
    );

endinterface

`default_nettype wire

// File: source/ic_pkg.sv
`default_nettype none

`include "ic_settings.svh"

package ic_pkg;

    // One flit as carried through all three stages
    typedef logic [`IC_FLIT_WIDTH-1:0] flit_t;

    // Next-hop node address
    typedef logic [`IC_ADDR_WIDTH-1:0] addr_t;

    // Total node count, also the number of destinations
    localparam int NUM_NODES = `IC_NUM_PARTS * `IC_NODES_PER_PART;

endpackage

`default_nettype wire

// File: include/ic_settings.svh
`ifndef IC_SETTINGS_SVH
`define IC_SETTINGS_SVH

// Width of one flit word
`define IC_FLIT_WIDTH 16

// Next-hop address width, wide enough for every destination node
`define IC_ADDR_WIDTH 4

// Source nodes grouped under one partition arbiter
`define IC_NODES_PER_PART 2

// Partitions competing in the stage 2 selector
`define IC_NUM_PARTS 2

`endif
